//--- design/pic_pkg.sv
`default_nettype none

package pic_pkg;

	// Number of interrupt request levels handled by the controller.
	localparam int irq_w = 8;

	typedef logic [2:0] level_t;

	// Initialization progress through the ICW sequence.
	typedef enum logic [1:0] {
		INIT_IDLE,
		INIT_ICW2,
		INIT_ICW4,
		INIT_READY
	} init_state_t;

	// Progress through the two-pulse INTA sequence.
	typedef enum logic [2:0] {
		ACK_IDLE,
		ACK_FIRST,
		ACK_BETWEEN,
		ACK_SECOND,
		ACK_DONE
	} ack_state_t;

	// OCW2 bits 7:5 encodings.
	typedef enum logic [2:0] {
		EOI_NONE        = 3'b000,
		EOI_NONSPECIFIC = 3'b001,
		EOI_SPECIFIC    = 3'b011
	} eoi_op_t;

endpackage

`default_nettype wire

//--- design/pic_init_seq.sv
`timescale 1ns/100ps
`default_nettype none

module pic_init_seq
	import pic_pkg::*;
(
	input wire clk,
	input wire arst_n,
	input wire icw1_wr,
	input wire a0_wr,
	input wire [7:0] din,
	output logic [4:0] vector_base,
	output logic level_mode,
	output logic auto_eoi,
	output logic ocw1_wr,
	output logic ocw2_wr_en
);

	init_state_t state;
	logic icw4_req;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= INIT_IDLE;
			vector_base <= 5'd0;
			level_mode <= 1'b0;
			auto_eoi <= 1'b0;
			icw4_req <= 1'b0;
		end
		else if (icw1_wr)
		begin
			// ICW1 restarts the sequence from any state.
			state <= INIT_ICW2;
			level_mode <= din[3];
			icw4_req <= din[0];
			auto_eoi <= 1'b0;
		end
		else if (a0_wr)
		begin
			case (state)
				INIT_ICW2:
				begin
					vector_base <= din[7:3];
					if (icw4_req)
						state <= INIT_ICW4;
					else
						state <= INIT_READY;
				end
				INIT_ICW4:
				begin
					auto_eoi <= din[1];
					state <= INIT_READY;
				end
				default:
					state <= state;
			endcase
		end
	end

	// After initialization an a0 write is a mask write (OCW1).
	assign ocw1_wr = a0_wr && (state == INIT_READY);

	// Enables both OCW2 and OCW3 in the top level decode.
	assign ocw2_wr_en = (state == INIT_READY);

endmodule

`default_nettype wire

//--- design/pic_request_regs.sv
`timescale 1ns/100ps
`default_nettype none

module pic_request_regs
	import pic_pkg::*;
(
	input wire clk,
	input wire arst_n,
	input wire [irq_w-1:0] ir,
	input wire level_mode,
	input wire init_clear,
	input wire mask_wr,
	input wire [7:0] din,
	input wire [irq_w-1:0] isr_set,
	input wire [irq_w-1:0] irr_clear,
	input wire [irq_w-1:0] isr_clear,
	output logic [irq_w-1:0] irr,
	output logic [irq_w-1:0] isr,
	output logic [irq_w-1:0] imr
);

	logic [irq_w-1:0] ir_q;
	logic [irq_w-1:0] ir_q2;
	logic [irq_w-1:0] ir_set;
	logic [irq_w-1:0] ir_keep;
	logic [irq_w-1:0] irr_next;

	// In level mode a request lasts only as long as its line is high.
	always_comb
	begin
		if (level_mode)
		begin
			ir_set = ir_q;
			ir_keep = ir_q;
		end
		else
		begin
			ir_set = ir_q & ~ir_q2;
			ir_keep = '1;
		end
		irr_next = ((irr & ir_keep) | ir_set) & ~irr_clear;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ir_q <= '0;
			ir_q2 <= '0;
			irr <= '0;
			isr <= '0;
			imr <= '0;
		end
		else
		begin
			ir_q <= ir;
			ir_q2 <= ir_q;
			if (init_clear)
			begin
				irr <= '0;
				isr <= '0;
				imr <= '0;
			end
			else
			begin
				irr <= irr_next;
				isr <= (isr | isr_set) & ~isr_clear;
				if (mask_wr)
					imr <= din;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/pic_priority.sv
`timescale 1ns/100ps
`default_nettype none

module pic_priority
	import pic_pkg::*;
(
	input wire [irq_w-1:0] irr,
	input wire [irq_w-1:0] isr,
	input wire [irq_w-1:0] imr,
	output logic req_valid,
	output level_t req_level,
	output logic [irq_w-1:0] isr_top
);

	logic [irq_w-1:0] pending;
	logic found;
	logic blocked;

	assign pending = irr & ~imr;

	// Level 0 is highest. A request is blocked by any in-service level
	// of equal or higher priority.
	always_comb
	begin
		found = 1'b0;
		blocked = 1'b0;
		req_valid = 1'b0;
		req_level = '0;
		for (int i = 0; i < irq_w; i++)
		begin
			blocked = blocked | isr[i];
			if (!found && pending[i])
			begin
				found = 1'b1;
				req_level = level_t'(i);
				req_valid = !blocked;
			end
		end
	end

	// Lowest set ISR bit, which is the highest level in service.
	assign isr_top = isr & (~isr + irq_w'(1));

endmodule

`default_nettype wire

//--- design/pic_ack_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pic_ack_ctrl
	import pic_pkg::*;
(
	input wire clk,
	input wire arst_n,
	input wire inta_n,
	input wire rd,
	input wire ocw2_wr,
	input wire ocw3_wr,
	input wire [7:0] din,
	input wire req_valid,
	input wire level_t req_level,
	input wire [irq_w-1:0] isr_top,
	input wire [irq_w-1:0] irr,
	input wire [irq_w-1:0] isr,
	input wire [4:0] vector_base,
	input wire auto_eoi,
	output logic int_out,
	output logic [irq_w-1:0] isr_set,
	output logic [irq_w-1:0] irr_clear,
	output logic [irq_w-1:0] isr_clear,
	output logic [7:0] dout,
	output logic dout_en
);

	ack_state_t state;
	eoi_op_t eoi_op;
	level_t ack_level;
	logic ack_valid;
	logic inta_q;
	logic inta_q2;
	logic inta_fall;
	logic inta_rise;
	logic read_isr;
	logic rd_q;
	logic take;
	logic [irq_w-1:0] eoi_clear;
	logic [irq_w-1:0] auto_clear;

	assign inta_fall = inta_q2 & ~inta_q;
	assign inta_rise = ~inta_q2 & inta_q;
	assign take = (state == ACK_IDLE) && inta_fall && req_valid;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= ACK_IDLE;
			inta_q <= 1'b1;
			inta_q2 <= 1'b1;
			ack_valid <= 1'b0;
			int_out <= 1'b0;
			read_isr <= 1'b0;
			rd_q <= 1'b0;
		end
		else
		begin
			inta_q <= inta_n;
			inta_q2 <= inta_q;
			rd_q <= rd;
			if (ocw3_wr && din[1])
				read_isr <= din[0];
			case (state)
				ACK_IDLE:
				begin
					int_out <= req_valid;
					if (inta_fall)
					begin
						state <= ACK_FIRST;
						ack_valid <= req_valid;
					end
				end
				ACK_FIRST:
					if (inta_rise)
					begin
						int_out <= 1'b0;
						state <= ACK_BETWEEN;
					end
				ACK_BETWEEN:
					if (inta_fall)
						state <= ACK_SECOND;
				ACK_SECOND:
					if (inta_rise)
						state <= ACK_DONE;
				default:
					state <= ACK_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			ack_level <= req_level;
	end

	always_comb
	begin
		case (din[7:5])
			3'b001: eoi_op = EOI_NONSPECIFIC;
			3'b011: eoi_op = EOI_SPECIFIC;
			default: eoi_op = EOI_NONE;
		endcase
		eoi_clear = '0;
		if (ocw2_wr && eoi_op == EOI_NONSPECIFIC)
			eoi_clear = isr_top;
		else if (ocw2_wr && eoi_op == EOI_SPECIFIC)
			eoi_clear = irq_w'(1) << din[2:0];
	end

	// Auto-EOI retires the level as the second INTA pulse ends.
	assign auto_clear = (state == ACK_SECOND && inta_rise && auto_eoi && ack_valid) ?
		(irq_w'(1) << ack_level) : '0;
	assign isr_clear = eoi_clear | auto_clear;
	assign isr_set = take ? (irq_w'(1) << req_level) : '0;
	assign irr_clear = isr_set;

	assign dout_en = (state == ACK_SECOND) || rd_q;

	always_comb
	begin
		if (state == ACK_SECOND)
			dout = {vector_base, ack_level};
		else if (rd_q)
			dout = read_isr ? isr : irr;
		else
			dout = 8'h00;
	end

endmodule

`default_nettype wire

//--- design/pic_top.sv
`timescale 1ns/100ps
`default_nettype none

module pic_top
	import pic_pkg::*;
(
	input wire clk,
	input wire arst_n,
	input wire wr,
	input wire rd,
	input wire a0,
	input wire [7:0] din,
	input wire inta_n,
	input wire [irq_w-1:0] ir,
	output logic [7:0] dout,
	output logic dout_en,
	output logic int_out
);

	logic wr_q;
	logic a0_q;
	logic [7:0] din_q;
	logic icw1_wr;
	logic a0_wr;
	logic ocw1_wr;
	logic ocw2_wr;
	logic ocw3_wr;
	logic ocw2_wr_en;
	logic [4:0] vector_base;
	logic level_mode;
	logic auto_eoi;
	logic req_valid;
	level_t req_level;
	logic [irq_w-1:0] isr_top;
	logic [irq_w-1:0] irr;
	logic [irq_w-1:0] isr;
	logic [irq_w-1:0] imr;
	logic [irq_w-1:0] isr_set;
	logic [irq_w-1:0] irr_clear;
	logic [irq_w-1:0] isr_clear;

	// The write is registered so it acts one clock after it is sampled.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_q <= 1'b0;
			a0_q <= 1'b0;
		end
		else
		begin
			wr_q <= wr;
			a0_q <= a0;
		end
	end

	always_ff @(posedge clk)
	begin
		din_q <= din;
	end

	assign icw1_wr = wr_q && !a0_q && din_q[4];
	assign a0_wr = wr_q && a0_q;
	assign ocw2_wr = wr_q && !a0_q && (din_q[4:3] == 2'b00) && ocw2_wr_en;
	assign ocw3_wr = wr_q && !a0_q && (din_q[4:3] == 2'b01) && ocw2_wr_en;

	pic_init_seq u_init_seq (
		.clk(clk),
		.arst_n(arst_n),
		.icw1_wr(icw1_wr),
		.a0_wr(a0_wr),
		.din(din_q),
		.vector_base(vector_base),
		.level_mode(level_mode),
		.auto_eoi(auto_eoi),
		.ocw1_wr(ocw1_wr),
		.ocw2_wr_en(ocw2_wr_en)
	);

	pic_request_regs u_request_regs (
		.clk(clk),
		.arst_n(arst_n),
		.ir(ir),
		.level_mode(level_mode),
		.init_clear(icw1_wr),
		.mask_wr(ocw1_wr),
		.din(din_q),
		.isr_set(isr_set),
		.irr_clear(irr_clear),
		.isr_clear(isr_clear),
		.irr(irr),
		.isr(isr),
		.imr(imr)
	);

	pic_priority u_priority (
		.irr(irr),
		.isr(isr),
		.imr(imr),
		.req_valid(req_valid),
		.req_level(req_level),
		.isr_top(isr_top)
	);

	pic_ack_ctrl u_ack_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.inta_n(inta_n),
		.rd(rd),
		.ocw2_wr(ocw2_wr),
		.ocw3_wr(ocw3_wr),
		.din(din_q),
		.req_valid(req_valid),
		.req_level(req_level),
		.isr_top(isr_top),
		.irr(irr),
		.isr(isr),
		.vector_base(vector_base),
		.auto_eoi(auto_eoi),
		.int_out(int_out),
		.isr_set(isr_set),
		.irr_clear(irr_clear),
		.isr_clear(isr_clear),
		.dout(dout),
		.dout_en(dout_en)
	);

endmodule

`default_nettype wire

//--- verification/pic_checker.sv
`timescale 1ns/100ps
`default_nettype none

module pic_checker (
	input wire clk,
	input wire [7:0] dout,
	input wire dout_en,
	input wire int_out,
	input wire check_arm,
	input wire [3:0] check_kind,
	input wire [7:0] check_value,
	output logic check_done,
	output logic [15:0] value_errors,
	output logic [15:0] missing_count
);

	localparam logic [3:0] kind_ack = 4'h3;
	localparam logic [3:0] kind_int = 4'h5;
	localparam int dout_wait_limit = 16;
	localparam int int_window = 4;

	// An expectation is picked up on a rising edge and the DUT outputs
	// are sampled on falling edges, where they are stable.
	initial
	begin
		int waited;
		check_done = 1'b0;
		value_errors = '0;
		missing_count = '0;
		forever
		begin
			@(posedge clk);
			if (!check_arm)
				check_done = 1'b0;
			else if (!check_done)
			begin
				if (check_kind == kind_int)
				begin
					repeat (int_window) @(negedge clk);
					if (int_out !== check_value[0])
					begin
						$display("error: time %0t signal int_out expected %0d actual %0d",
							$time, check_value[0], int_out);
						value_errors++;
					end
				end
				else
				begin
					waited = 0;
					@(negedge clk);
					while (!dout_en && waited < dout_wait_limit)
					begin
						@(negedge clk);
						waited++;
					end
					if (!dout_en)
					begin
						$display("At %0t the DUT never raised dout_en for the %s.", $time,
							(check_kind == kind_ack) ? "acknowledge" : "register read");
						missing_count++;
					end
					else if (dout !== check_value)
					begin
						$display("error: time %0t signal dout expected 8'h%02h actual 8'h%02h",
							$time, check_value, dout);
						value_errors++;
					end
				end
				@(posedge clk);
				check_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/pic_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pic_tb;

	localparam int period = 100;
	localparam logic [31:0] seed = 32'h9a52;
	localparam int cycles_per_line = 40;
	localparam string vector_file = "verification/pic_vectors.txt";
	localparam int max_vectors = 128;

	logic clk;
	logic arst_n;
	logic wr;
	logic rd;
	logic a0;
	logic [7:0] din;
	logic inta_n;
	logic [7:0] ir;
	wire [7:0] dout;
	wire dout_en;
	wire int_out;

	logic check_arm;
	logic [3:0] check_kind;
	logic [7:0] check_value;
	wire check_done;
	wire [15:0] value_errors;
	wire [15:0] missing_count;

	logic [15:0] vectors [0:max_vectors-1];
	logic [31:0] lfsr;
	int num_vectors;
	int bad_lines;
	int cycle_count = 0;
	int cycle_limit = 0;

	pic_top DUT (
		.clk(clk),
		.arst_n(arst_n),
		.wr(wr),
		.rd(rd),
		.a0(a0),
		.din(din),
		.inta_n(inta_n),
		.ir(ir),
		.dout(dout),
		.dout_en(dout_en),
		.int_out(int_out)
	);

	pic_checker u_checker (
		.clk(clk),
		.dout(dout),
		.dout_en(dout_en),
		.int_out(int_out),
		.check_arm(check_arm),
		.check_kind(check_kind),
		.check_value(check_value),
		.check_done(check_done),
		.value_errors(value_errors),
		.missing_count(missing_count)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(period / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, the vector run did not finish.", cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Galois LFSR with taps x^32 + x^31 + x^29 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			lfsr_next = (s >> 1) ^ 32'hd000_0001;
		else
			lfsr_next = s >> 1;
	endfunction

	task automatic idle_gap();
		logic [1:0] gap;
		lfsr = lfsr_next(lfsr);
		gap[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		gap[1] = lfsr[0];
		repeat (gap) @(negedge clk);
	endtask

	task automatic write_reg(input logic addr, input logic [7:0] data);
		wr = 1'b1;
		a0 = addr;
		din = data;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic arm_check(input logic [3:0] kind, input logic [7:0] value);
		check_kind = kind;
		check_value = value;
		check_arm = 1'b1;
	endtask

	// Waits for the checker, then releases the bus and the expectation together.
	task automatic finish_check();
		while (!check_done)
			@(negedge clk);
		check_arm = 1'b0;
		rd = 1'b0;
		inta_n = 1'b1;
		while (check_done)
			@(negedge clk);
	endtask

	task automatic acknowledge(input logic [7:0] expected);
		arm_check(4'h3, expected);
		inta_n = 1'b0;
		repeat (2) @(negedge clk);
		inta_n = 1'b1;
		repeat (3) @(negedge clk);
		inta_n = 1'b0;
		finish_check();
		while (dout_en)
			@(negedge clk);
		// One more cycle lets the FSM get back to idle.
		@(negedge clk);
	endtask

	task automatic read_reg(input logic [7:0] expected);
		arm_check(4'h4, expected);
		rd = 1'b1;
		finish_check();
	endtask

	task automatic expect_int(input logic level);
		arm_check(4'h5, {7'h00, level});
		finish_check();
	endtask

	initial
	begin
		logic [3:0] op;
		logic [3:0] arg;
		logic [7:0] data;
		wr = 1'b0;
		rd = 1'b0;
		a0 = 1'b0;
		din = 8'h00;
		inta_n = 1'b1;
		ir = 8'h00;
		arst_n = 1'b0;
		check_arm = 1'b0;
		check_kind = 4'h0;
		check_value = 8'h00;
		lfsr = seed;
		bad_lines = 0;
		for (int i = 0; i < max_vectors; i++)
			vectors[i] = 16'(i);
		$readmemh(vector_file, vectors);
		// A zero command word ends the list.
		num_vectors = 0;
		while (num_vectors < max_vectors && vectors[num_vectors][15:12] != 4'h0)
			num_vectors++;
		if (num_vectors == 0)
			$display("No vectors were read from %s.", vector_file);
		cycle_limit = num_vectors * cycles_per_line;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < num_vectors; i++)
		begin
			op = vectors[i][15:12];
			arg = vectors[i][11:8];
			data = vectors[i][7:0];
			case (op)
				4'h1: write_reg(arg[0], data);
				4'h2:
				begin
					ir = data;
					@(negedge clk);
				end
				4'h3: acknowledge(data);
				4'h4: read_reg(data);
				4'h5: expect_int(data[0]);
				default:
				begin
					$display("Vector %0d has an unknown command %h.", i, op);
					bad_lines++;
				end
			endcase
			idle_gap();
		end
		repeat (2) @(negedge clk);
		$display("Run done: %0d vectors, %0d value errors, %0d missing dout_en, %0d bad lines",
			num_vectors, value_errors, missing_count, bad_lines);
		if (value_errors == 0 && missing_count == 0 && bad_lines == 0 && num_vectors > 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- pic.f
design/pic_pkg.sv
design/pic_init_seq.sv
design/pic_request_regs.sv
design/pic_priority.sv
design/pic_ack_ctrl.sv
design/pic_top.sv
verification/pic_checker.sv
verification/pic_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= pic_tb
FILELIST ?= pic.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- verification/pic_vectors.txt
// Each word is four hex digits: command, a0, then the data byte.
// Commands: 1 write, 2 set ir, 3 acknowledge with vector, 4 read with value, 5 int_out level.
// Edge mode, vector base 0x40, auto-EOI off.
1013 1140 1101
// Basic acknowledge of level 4, then a held edge line stays quiet after EOI.
2010 5001 3044 5000 1020 5000 2000
// Level 2 wins over level 5, which waits for the non-specific EOI.
2024 5001 3042 5000 1020 5001 3045 1020 2000
// Mask level 3, then unmask it.
1108 2008 5000 1100 5001
// ISR read, specific EOI, then an IRR read of a masked request.
3043 100b 4008 1063 4000 1140 2048 5000 100a 4040 2000
// Re-initialize with auto-EOI.
1013 1140 1103 2002 5001 3041 100b 4000 2000
// Level mode requests again after EOI while the line is held.
101b 1140 1101 2001 5001 3040 5000 1020 5001 3040 1020 2000 5000
